/* vlog.f */
design/regPkg.sv
design/gprFile.sv
design/ctlRegFile.sv
design/regFileTop.sv
tests/regFileChecker.sv
tests/regFileTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= regFileTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/regFileTb.sv */
`default_nettype none

module regFileTb;

	timeunit 1ns;
	timeprecision 100ps;

	import regPkg::*;

	localparam int clockPeriod = 20;
	localparam int resetCycles = 10;
	localparam int setupCycles = 45;		// 32 general, 13 control
	localparam int commitCycles = 80;
	localparam int forwardCycles = 80;
	localparam int reloadCycles = 40;
	localparam int holdCycles = 80;
	localparam int mixedCycles = 400;
	localparam int totalCycles = resetCycles + setupCycles + commitCycles + forwardCycles
		+ reloadCycles + holdCycles + mixedCycles + 2;
	localparam int timeoutNs = totalCycles * clockPeriod * 3 / 2;

	logic clock;
	logic reset;
	logic hold;
	regIdx_t idRs;
	regIdx_t idRt;
	regIdx_t idCm;
	regWrite_t wbEx1;
	regWrite_t wbEx2;
	half_t nextPc;
	half_t nextLr;
	word_t nextSr;

	word_t valRs;
	word_t valRt;
	word_t valCm;
	word_t sr;
	word_t mmcr;
	word_t krr;
	half_t pc;
	half_t lr;
	half_t vbr;
	half_t gbr;
	half_t tbr;

	logic [159:0] testName;
	int checkCount;
	int errorCount;
	int holdLeft;

	regFileTop i_dut
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.idRs(idRs),
		.idRt(idRt),
		.idCm(idCm),
		.wbEx1(wbEx1),
		.wbEx2(wbEx2),
		.nextPc(nextPc),
		.nextLr(nextLr),
		.nextSr(nextSr),
		.valRs(valRs),
		.valRt(valRt),
		.valCm(valCm),
		.sr(sr),
		.mmcr(mmcr),
		.krr(krr),
		.pc(pc),
		.lr(lr),
		.vbr(vbr),
		.gbr(gbr),
		.tbr(tbr)
	);

	regFileChecker #(.clockPeriod(clockPeriod)) i_checker
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.idRs(idRs),
		.idRt(idRt),
		.idCm(idCm),
		.wbEx1(wbEx1),
		.wbEx2(wbEx2),
		.nextPc(nextPc),
		.nextLr(nextLr),
		.nextSr(nextSr),
		.valRs(valRs),
		.valRt(valRt),
		.valCm(valCm),
		.sr(sr),
		.mmcr(mmcr),
		.krr(krr),
		.pc(pc),
		.lr(lr),
		.vbr(vbr),
		.gbr(gbr),
		.tbr(tbr),
		.testName(testName),
		.checkCount(checkCount),
		.errorCount(errorCount)
	);

	initial
	begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	initial
	begin
		#(timeoutNs);
		$display("Timeout: the run did not finish within %0d ns", timeoutNs);
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		$display("TEST FAILED");
		$finish;
	end

	task automatic nextCycle();
		@(posedge clock);
		#2;
	endtask

	function automatic word_t randomWord();
		return {$urandom(), $urandom()};
	endfunction

	// Clustered picks hit PC, LR, SR and ZZR often
	function automatic regIdx_t randomIdx(input bit clustered);
		regIdx_t result;
		result = regIdx_t'($urandom_range(0, 31));
		if (clustered)
		begin
			case ($urandom_range(0, 3))
				0: result = crPc;
				1: result = crLr;
				2: result = crSr;
				default: result = crZzr;
			endcase
		end
		return result;
	endfunction

	function automatic regWrite_t randomWrite(input int validPct, input bit clustered);
		regWrite_t wb;
		wb.valid = ($urandom_range(0, 99) < validPct);
		wb.isCr = 1'($urandom_range(0, 1));
		wb.idx = randomIdx(clustered);
		wb.value = randomWord();
		return wb;
	endfunction

	task automatic driveRandom(input int ex1Pct, input int ex2Pct, input bit clustered);
		wbEx1 = randomWrite(ex1Pct, clustered);
		wbEx2 = randomWrite(ex2Pct, clustered);
		idRs = randomIdx(clustered);
		idRt = randomIdx(clustered);
		idCm = randomIdx(clustered);
		nextPc = $urandom();
		nextLr = $urandom();
		nextSr = randomWord();
	endtask

	initial
	begin
		void'($urandom(32'h5b84));
		reset = 1'b1;
		hold = 1'b0;
		idRs = '0;
		idRt = '0;
		idCm = '0;
		wbEx1 = '0;
		wbEx2 = '0;
		nextPc = '0;
		nextLr = '0;
		nextSr = '0;
		holdLeft = 0;

		testName = "reset";
		repeat (resetCycles) @(posedge clock);
		#2;
		reset = 1'b0;

		testName = "setup";
		for (int i = 0; i < 32; i++)
		begin
			wbEx2 = '{1'b1, 1'b0, regIdx_t'(i), randomWord()};
			nextCycle();
		end
		for (int i = 1; i < 14; i++)
		begin
			wbEx2 = '{1'b1, 1'b1, regIdx_t'(i), randomWord()};
			nextCycle();
		end

		testName = "commitReadback";
		for (int n = 0; n < commitCycles; n++)
		begin
			driveRandom(0, 80, (n % 4) == 0);
			nextCycle();
		end

		testName = "forwarding";
		for (int n = 0; n < forwardCycles; n++)
		begin
			driveRandom(70, 70, (n % 3) != 0);
			nextCycle();
		end

		testName = "nextStateReload";
		for (int n = 0; n < reloadCycles; n++)
		begin
			driveRandom(0, 50, 1'b1);
			nextCycle();
		end

		testName = "hold";
		for (int n = 0; n < holdCycles; n++)
		begin
			if (holdLeft == 0)
			begin
				hold = ~hold;		// Alternate stretches
				holdLeft = $urandom_range(1, 8);
			end
			holdLeft--;
			driveRandom(50, 70, (n % 2) == 0);
			nextCycle();
		end
		hold = 1'b0;

		testName = "mixedTraffic";
		for (int n = 0; n < mixedCycles; n++)
		begin
			hold = ($urandom_range(0, 99) < 20);
			driveRandom(50, 60, (n % 2) == 0);
			nextCycle();
		end

		testName = "done";
		hold = 1'b0;
		wbEx1 = '0;
		wbEx2 = '0;
		nextCycle();
		nextCycle();

		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0 && checkCount > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/regFileChecker.sv */
`default_nettype none

module regFileChecker
#(
	parameter int clockPeriod = 20
)
(
	input wire logic clock,
	input wire logic reset,
	input wire logic hold,

	input wire regPkg::regIdx_t idRs,
	input wire regPkg::regIdx_t idRt,
	input wire regPkg::regIdx_t idCm,

	input wire regPkg::regWrite_t wbEx1,
	input wire regPkg::regWrite_t wbEx2,

	input wire regPkg::half_t nextPc,
	input wire regPkg::half_t nextLr,
	input wire regPkg::word_t nextSr,

	input wire regPkg::word_t valRs,
	input wire regPkg::word_t valRt,
	input wire regPkg::word_t valCm,
	input wire regPkg::word_t sr,
	input wire regPkg::word_t mmcr,
	input wire regPkg::word_t krr,
	input wire regPkg::half_t pc,
	input wire regPkg::half_t lr,
	input wire regPkg::half_t vbr,
	input wire regPkg::half_t gbr,
	input wire regPkg::half_t tbr,

	input wire logic [159:0] testName,		// Printed with %s

	output int checkCount,
	output int errorCount
);

	timeunit 1ns;
	timeprecision 100ps;

	import regPkg::*;

	word_t gprShadow [32];
	word_t crShadow [32];		// Only 0 to 13 are used
	logic [31:0] gprKnown = '0;
	logic [31:0] crKnown = '0;

	int checks = 0;
	int errors = 0;

	assign checkCount = checks;
	assign errorCount = errors;

	function automatic logic isNarrow(input regIdx_t idx);
		return !(idx == crSr || idx == crExsr || idx == crMmcr || idx == crKrr);
	endfunction

	task automatic storeCr(input regIdx_t idx, input word_t value);
		crShadow[idx] = isNarrow(idx) ? {32'b0, value[31:0]} : value;
		crKnown[idx] = 1'b1;
	endtask

	function automatic logic ex2Writes(input regIdx_t idx);
		return wbEx2.valid && wbEx2.isCr && wbEx2.idx == idx;
	endfunction

	// Shadow model follows the commit rule at each rising edge
	always @(posedge clock)
	begin
		if (!hold && wbEx2.valid && !wbEx2.isCr)		// General file has no reset
		begin
			gprShadow[wbEx2.idx] = wbEx2.value;
			gprKnown[wbEx2.idx] = 1'b1;
		end

		if (reset)
		begin
			storeCr(crPc, '0);
			storeCr(crLr, '0);
			storeCr(crSr, '0);
			storeCr(crVbr, '0);
			storeCr(crGbr, '0);
			storeCr(crTbr, '0);
			storeCr(crMmcr, '0);
			storeCr(crKrr, '0);
		end
		else if (!hold)
		begin
			if (wbEx2.valid && wbEx2.isCr && wbEx2.idx >= crLr && wbEx2.idx <= crKrr)
				storeCr(wbEx2.idx, wbEx2.value);
			if (!ex2Writes(crLr))
				storeCr(crLr, word_t'(nextLr));
			if (!ex2Writes(crSr))
				storeCr(crSr, nextSr);
			storeCr(crPc, word_t'(nextPc));		// PC writes never land
		end
	end

	// EX1 beats EX2, and both beat storage
	function automatic word_t expectedRead(input regIdx_t idx, input logic isCr,
		output logic known);
		word_t result;
		known = 1'b1;
		if (isCr && idx > crKrr)
			result = '0;		// ZZR and unused indices
		else if (wbEx1.valid && wbEx1.isCr == isCr && wbEx1.idx == idx)
			result = wbEx1.value;
		else if (wbEx2.valid && wbEx2.isCr == isCr && wbEx2.idx == idx)
			result = wbEx2.value;
		else if (isCr)
		begin
			result = crShadow[idx];
			known = crKnown[idx];
		end
		else
		begin
			result = gprShadow[idx];
			known = gprKnown[idx];
		end
		return result;
	endfunction

	task automatic compareValue(input string what, input word_t expected, input word_t actual,
		input logic known);
		if (known)
		begin
			checks++;
			if (actual !== expected)
			begin
				errors++;
				$display("** Error [%0s] %0s: expected %h, actual %h",
					testName, what, expected, actual);
			end
		end
	endtask

	task automatic checkOutputs();
		word_t expected;
		logic known;
		expected = expectedRead(idRs, 1'b0, known);
		compareValue("valRs", expected, valRs, known);
		expected = expectedRead(idRt, 1'b0, known);
		compareValue("valRt", expected, valRt, known);
		expected = expectedRead(idCm, 1'b1, known);
		compareValue("valCm", expected, valCm, known);

		compareValue("pc", crShadow[crPc], word_t'(pc), crKnown[crPc]);
		compareValue("lr", crShadow[crLr], word_t'(lr), crKnown[crLr]);
		compareValue("sr", crShadow[crSr], sr, crKnown[crSr]);
		compareValue("vbr", crShadow[crVbr], word_t'(vbr), crKnown[crVbr]);
		compareValue("gbr", crShadow[crGbr], word_t'(gbr), crKnown[crGbr]);
		compareValue("tbr", crShadow[crTbr], word_t'(tbr), crKnown[crTbr]);
		compareValue("mmcr", crShadow[crMmcr], mmcr, crKnown[crMmcr]);
		compareValue("krr", crShadow[crKrr], krr, crKnown[crKrr]);
	endtask

	// Sample just before the next edge
	always @(posedge clock)
	begin
		#(clockPeriod - 1);
		checkOutputs();
	end

endmodule

`default_nettype wire

/* design/regFileTop.sv */
`default_nettype none

module regFileTop
(
	input wire logic clock,
	input wire logic reset,
	input wire logic hold,

	input wire regPkg::regIdx_t idRs,
	input wire regPkg::regIdx_t idRt,
	input wire regPkg::regIdx_t idCm,

	input wire regPkg::regWrite_t wbEx1,		// Execute stage 1
	input wire regPkg::regWrite_t wbEx2,		// Execute stage 2 commits

	input wire regPkg::half_t nextPc,
	input wire regPkg::half_t nextLr,
	input wire regPkg::word_t nextSr,

	output regPkg::word_t valRs,
	output regPkg::word_t valRt,
	output regPkg::word_t valCm,
	output regPkg::word_t sr,
	output regPkg::word_t mmcr,
	output regPkg::word_t krr,
	output regPkg::half_t pc,
	output regPkg::half_t lr,
	output regPkg::half_t vbr,
	output regPkg::half_t gbr,
	output regPkg::half_t tbr
);

	// General registers have no reset
	gprFile i_gprFile
	(
		.clock(clock),
		.hold(hold),
		.idRs(idRs),
		.idRt(idRt),
		.wbEx1(wbEx1),
		.wbEx2(wbEx2),
		.valRs(valRs),
		.valRt(valRt)
	);

	ctlRegFile i_ctlRegFile
	(
		.clock(clock),
		.reset(reset),
		.hold(hold),
		.idCm(idCm),
		.wbEx1(wbEx1),
		.wbEx2(wbEx2),
		.nextPc(nextPc),
		.nextLr(nextLr),
		.nextSr(nextSr),
		.valCm(valCm),
		.sr(sr),
		.mmcr(mmcr),
		.krr(krr),
		.pc(pc),
		.lr(lr),
		.vbr(vbr),
		.gbr(gbr),
		.tbr(tbr)
	);

endmodule

`default_nettype wire

/* design/ctlRegFile.sv */
`default_nettype none

module ctlRegFile
(
	input wire logic clock,
	input wire logic reset,
	input wire logic hold,

	input wire regPkg::regIdx_t idCm,		// Source C

	input wire regPkg::regWrite_t wbEx1,
	input wire regPkg::regWrite_t wbEx2,

	input wire regPkg::half_t nextPc,
	input wire regPkg::half_t nextLr,
	input wire regPkg::word_t nextSr,

	output regPkg::word_t valCm,
	output regPkg::word_t sr,
	output regPkg::word_t mmcr,
	output regPkg::word_t krr,
	output regPkg::half_t pc,
	output regPkg::half_t lr,
	output regPkg::half_t vbr,
	output regPkg::half_t gbr,
	output regPkg::half_t tbr
);

	import regPkg::*;

	half_t pcReg;
	half_t lrReg;
	word_t srReg;
	half_t vbrReg;
	half_t spcReg;
	half_t sspReg;
	half_t gbrReg;
	half_t tbrReg;
	half_t teaReg;
	word_t exsrReg;

	half_t ttbVal;		// Zero without MMU
	half_t sttbVal;		// Zero without MMU

	word_t storedCm;

	function automatic logic ex2Targets(regWrite_t wb, regIdx_t idx);
		return wb.valid && wb.isCr && wb.idx == idx;
	endfunction

	assign pc = pcReg;
	assign lr = lrReg;
	assign sr = srReg;
	assign vbr = vbrReg;
	assign gbr = gbrReg;
	assign tbr = tbrReg;

	always_comb
	begin
		case (idCm)
			crPc: storedCm = word_t'(pcReg);
			crLr: storedCm = word_t'(lrReg);
			crSr: storedCm = srReg;
			crVbr: storedCm = word_t'(vbrReg);
			crSpc: storedCm = word_t'(spcReg);
			crSsp: storedCm = word_t'(sspReg);
			crGbr: storedCm = word_t'(gbrReg);
			crTbr: storedCm = word_t'(tbrReg);
			crTea: storedCm = word_t'(teaReg);
			crExsr: storedCm = exsrReg;
			crTtb: storedCm = word_t'(ttbVal);
			crMmcr: storedCm = mmcr;
			crSttb: storedCm = word_t'(sttbVal);
			crKrr: storedCm = krr;
			crZzr: storedCm = '0;
			default: storedCm = '0;		// Unused indices 14 to 30
		endcase

		// ZZR and unused indices never forward
		if (idCm <= crKrr)
			valCm = forwardValue(idCm, 1'b1, storedCm, wbEx1, wbEx2);
		else
			valCm = storedCm;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pcReg <= '0;
			lrReg <= '0;
			srReg <= '0;
			vbrReg <= '0;
			gbrReg <= '0;
			tbrReg <= '0;
		end
		else if (!hold)
		begin
			pcReg <= nextPc;		// EX2 writes of PC are dropped
			lrReg <= ex2Targets(wbEx2, crLr) ? half_t'(wbEx2.value) : nextLr;
			srReg <= ex2Targets(wbEx2, crSr) ? wbEx2.value : nextSr;
			vbrReg <= ex2Targets(wbEx2, crVbr) ? half_t'(wbEx2.value) : vbrReg;
			gbrReg <= ex2Targets(wbEx2, crGbr) ? half_t'(wbEx2.value) : gbrReg;
			tbrReg <= ex2Targets(wbEx2, crTbr) ? half_t'(wbEx2.value) : tbrReg;
		end

		// Not cleared by reset
		if (!reset && !hold)
		begin
			spcReg <= ex2Targets(wbEx2, crSpc) ? half_t'(wbEx2.value) : spcReg;
			sspReg <= ex2Targets(wbEx2, crSsp) ? half_t'(wbEx2.value) : sspReg;
			teaReg <= ex2Targets(wbEx2, crTea) ? half_t'(wbEx2.value) : teaReg;
			exsrReg <= ex2Targets(wbEx2, crExsr) ? wbEx2.value : exsrReg;
		end
	end

	generate
		if (enableMmu)
		begin : gMmu
			half_t ttbReg;
			half_t sttbReg;
			word_t mmcrReg;
			word_t krrReg;

			always_ff @(posedge clock)
			begin
				if (reset)
				begin
					mmcrReg <= '0;
					krrReg <= '0;
				end
				else if (!hold)
				begin
					ttbReg <= ex2Targets(wbEx2, crTtb) ? half_t'(wbEx2.value) : ttbReg;
					mmcrReg <= ex2Targets(wbEx2, crMmcr) ? wbEx2.value : mmcrReg;
					sttbReg <= ex2Targets(wbEx2, crSttb) ? half_t'(wbEx2.value) : sttbReg;
					krrReg <= ex2Targets(wbEx2, crKrr) ? wbEx2.value : krrReg;
				end
			end

			assign ttbVal = ttbReg;
			assign sttbVal = sttbReg;
			assign mmcr = mmcrReg;
			assign krr = krrReg;
		end
		else
		begin : gNoMmu
			assign ttbVal = '0;
			assign sttbVal = '0;
			assign mmcr = '0;
			assign krr = '0;
		end
	endgenerate

endmodule

`default_nettype wire

/* design/gprFile.sv */
`default_nettype none

module gprFile
(
	input wire logic clock,
	input wire logic hold,

	input wire regPkg::regIdx_t idRs,		// Source S
	input wire regPkg::regIdx_t idRt,		// Source T

	input wire regPkg::regWrite_t wbEx1,
	input wire regPkg::regWrite_t wbEx2,

	output regPkg::word_t valRs,
	output regPkg::word_t valRt
);

	import regPkg::*;

	word_t gprArray [32];

	word_t storedRs;
	word_t storedRt;
	logic commitEx2;

	// Stored values before forwarding
	always_comb
	begin
		storedRs = gprArray[idRs];
		storedRt = gprArray[idRt];
	end

	// General space only, so isCr must be low
	always_comb
	begin
		valRs = forwardValue(idRs, 1'b0, storedRs, wbEx1, wbEx2);
		valRt = forwardValue(idRt, 1'b0, storedRt, wbEx1, wbEx2);
	end

	assign commitEx2 = wbEx2.valid && !wbEx2.isCr && !hold;

	// Only EX2 reaches the array
	always_ff @(posedge clock)
	begin
		if (commitEx2)
		begin
			gprArray[wbEx2.idx] <= wbEx2.value;
		end
	end

endmodule

`default_nettype wire

/* design/regPkg.sv */
`default_nettype none

package regPkg;

	localparam int wordWidth = 64;
	localparam int halfWidth = 32;
	localparam int idxWidth = 5;

	typedef logic [wordWidth-1:0] word_t;		// Data word
	typedef logic [halfWidth-1:0] half_t;		// Narrow control register storage
	typedef logic [idxWidth-1:0] regIdx_t;		// Index within one file

	// Build switch for TTB, MMCR, STTB and KRR
	localparam bit enableMmu = 1'b1;

	localparam regIdx_t crPc = 5'd0;
	localparam regIdx_t crLr = 5'd1;
	localparam regIdx_t crSr = 5'd2;
	localparam regIdx_t crVbr = 5'd3;
	localparam regIdx_t crSpc = 5'd4;
	localparam regIdx_t crSsp = 5'd5;
	localparam regIdx_t crGbr = 5'd6;
	localparam regIdx_t crTbr = 5'd7;
	localparam regIdx_t crTea = 5'd8;
	localparam regIdx_t crExsr = 5'd9;
	localparam regIdx_t crTtb = 5'd10;		// MMU
	localparam regIdx_t crMmcr = 5'd11;		// MMU
	localparam regIdx_t crSttb = 5'd12;		// MMU
	localparam regIdx_t crKrr = 5'd13;		// MMU
	localparam regIdx_t crZzr = 5'd31;		// Zero register

	typedef struct packed
	{
		logic valid;
		logic isCr;		// Index names a control register
		regIdx_t idx;
		word_t value;
	} regWrite_t;

	// EX1 beats EX2, both beat the stored value
	function automatic word_t forwardValue(
		regIdx_t idx,
		logic isCr,
		word_t stored,
		regWrite_t ex1,
		regWrite_t ex2
	);
		word_t result;
		result = stored;
		if (ex2.valid && ex2.isCr == isCr && ex2.idx == idx)
			result = ex2.value;
		if (ex1.valid && ex1.isCr == isCr && ex1.idx == idx)
			result = ex1.value;
		return result;
	endfunction

endpackage

`default_nettype wire
